// ==== Makefile ====
# Verilator build for the async fifo testbench
# make lint   static checks on the full source list
# make sim    build and run, pass only if the log holds the pass line
# make clean  remove build output and log

LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --assert -f vlog.f --top-module tb_oh_fifo_async

sim:
	verilator --binary --timing --assert -j 0 -f vlog.f \
		--top-module tb_oh_fifo_async -Mdir obj_dir -o sim_fifo
	./obj_dir/sim_fifo | tee $(LOG)
	grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== oh_fifo_async.sv ====
/*
 * async fifo top, write side on wr_clk and read side on rd_clk
 * each reset must be synchronous to its own clock
 * no back-pressure, strobes against full or empty are lost
 */
`timescale 1ns/1ps
`include "oh_fifo_consts.svh"

module oh_fifo_async (
   // clocks and resets
   input  logic               wr_clk,     // write clock
   input  logic               rd_clk,     // read clock
   input  logic               wr_rst,     // sync to wr_clk
   input  logic               rd_rst,     // sync to rd_clk
   // write side
   input  logic               wr_en,      // write strobe
   input  oh_fifo_pkg::data_t wr_din,     // write data
   output logic               full,       // writes dropped while high
   // read side
   input  logic               rd_en,      // read strobe
   output logic               empty,      // reads dropped while high
   output logic               rd_valid,   // one cycle after accepted read
   output oh_fifo_pkg::data_t rd_dout,    // read data
   // bist write port, write clock domain
   input  logic               bist_en,    // bist owns ram write side
   input  logic               bist_we,    // bist write strobe
   input  oh_fifo_pkg::data_t bist_wem,   // bist per bit enable
   input  oh_fifo_pkg::addr_t bist_addr,  // bist slot
   input  oh_fifo_pkg::data_t bist_din    // bist data
);

   logic               mem_wr_en;
   oh_fifo_pkg::addr_t mem_wr_addr;
   logic               mem_rd_en;
   oh_fifo_pkg::addr_t mem_rd_addr;
   oh_fifo_pkg::ptr_t  wr_gray;      // crosses to read domain
   oh_fifo_pkg::ptr_t  rd_gray;      // crosses to write domain

   // ################################################
   // pointer halves
   // ################################################
   oh_fifo_wptr oh_fifo_wptr (
      .wr_clk      (wr_clk),
      .wr_rst      (wr_rst),
      .wr_en       (wr_en),
      .bist_en     (bist_en),   // blocks functional writes
      .rd_gray     (rd_gray),
      .full        (full),
      .mem_wr_en   (mem_wr_en),
      .mem_wr_addr (mem_wr_addr),
      .wr_gray     (wr_gray)
   );

   oh_fifo_rptr oh_fifo_rptr (
      .rd_clk      (rd_clk),
      .rd_rst      (rd_rst),
      .rd_en       (rd_en),
      .wr_gray     (wr_gray),
      .empty       (empty),
      .rd_valid    (rd_valid),
      .mem_rd_en   (mem_rd_en),
      .mem_rd_addr (mem_rd_addr),
      .rd_gray     (rd_gray)
   );

   // ################################################
   // storage
   // ################################################
   oh_memory_dp #(
      .DW    (`FIFO_DW),
      .DEPTH (`FIFO_DEPTH)
   ) oh_memory_dp (
      .wr_clk    (wr_clk),
      .wr_en     (mem_wr_en),
      .wr_addr   (mem_wr_addr),
      .wr_din    (wr_din),
      .rd_clk    (rd_clk),
      .rd_en     (mem_rd_en),
      .rd_addr   (mem_rd_addr),
      .rd_dout   (rd_dout),
      .bist_en   (bist_en),
      .bist_we   (bist_we),
      .bist_wem  (bist_wem),
      .bist_addr (bist_addr),
      .bist_din  (bist_din)
   );

endmodule

// ==== oh_fifo_consts.svh ====
/*
 * sizing macros for the async fifo and its memory
 * FIFO_DEPTH must be a power of two and FIFO_AW its log2
 * FIFO_AW of at least 2 is assumed by the full compare
 */
`ifndef OH_FIFO_CONSTS_SVH
`define OH_FIFO_CONSTS_SVH

// ################################################
// fifo geometry
// ################################################
`define FIFO_DW     32   // data width
`define FIFO_DEPTH  16   // entries, power of two
`define FIFO_AW     4    // log2 of depth

// ################################################
// clock crossing
// ################################################
`define FIFO_SYNC   2    // synchronizer flops per crossing

`endif

// ==== oh_fifo_pkg.sv ====
/*
 * plain typedefs shared by the fifo blocks
 * widths follow the sizing macros, pointers carry a wrap bit
 */
`include "oh_fifo_consts.svh"

package oh_fifo_pkg;

   // ################################################
   // payload
   // ################################################

   // one stored word, also used as a per bit write mask
   typedef logic [`FIFO_DW-1:0] data_t;

   // ################################################
   // addressing
   // ################################################

   // memory slot index
   typedef logic [`FIFO_AW-1:0] addr_t;

   // binary or gray pointer, msb is the wrap bit
   typedef logic [`FIFO_AW:0] ptr_t;

endpackage

// ==== oh_fifo_rptr.sv ====
/*
 * read domain pointer logic, all flops on rd_clk
 * wr_gray arrives from the write domain and is synchronized here
 * reads with empty high are dropped, rd_valid marks ram output
 */
`timescale 1ns/1ps
`include "oh_fifo_consts.svh"

module oh_fifo_rptr (
   input  logic               rd_clk,       // read clock
   input  logic               rd_rst,       // sync reset, read domain
   input  logic               rd_en,        // read strobe
   input  oh_fifo_pkg::ptr_t  wr_gray,      // write pointer, other domain
   output logic               empty,        // registered empty flag
   output logic               rd_valid,     // rd_dout valid this cycle
   output logic               mem_rd_en,    // ram read strobe
   output oh_fifo_pkg::addr_t mem_rd_addr,  // ram read slot
   output oh_fifo_pkg::ptr_t  rd_gray       // registered gray pointer
);

   oh_fifo_pkg::ptr_t rd_bin;                     // binary read pointer
   oh_fifo_pkg::ptr_t rd_bin_next;
   oh_fifo_pkg::ptr_t rd_gray_next;
   oh_fifo_pkg::ptr_t wr_gray_sync [`FIFO_SYNC];  // synchronizer chain
   logic              rd_inc;                     // accepted read

   assign rd_inc       = rd_en & ~empty;
   assign rd_bin_next  = rd_bin + oh_fifo_pkg::ptr_t'(rd_inc);
   assign rd_gray_next = (rd_bin_next >> 1) ^ rd_bin_next;

   assign mem_rd_en   = rd_inc;                 // ram registers on this edge
   assign mem_rd_addr = rd_bin[`FIFO_AW-1:0];   // drop wrap bit

   // ################################################
   // write pointer synchronizer
   // ################################################
   always_ff @(posedge rd_clk) begin
      if (rd_rst) begin
         for (int i = 0; i < `FIFO_SYNC; i++) begin
            wr_gray_sync[i] <= '0;
         end
      end else begin
         wr_gray_sync[0] <= wr_gray;  // first stage may go metastable
         for (int i = 1; i < `FIFO_SYNC; i++) begin
            wr_gray_sync[i] <= wr_gray_sync[i-1];
         end
      end
   end

   // ################################################
   // pointer, flag and valid
   // ################################################
   always_ff @(posedge rd_clk) begin
      if (rd_rst) begin
         rd_bin   <= '0;
         rd_gray  <= '0;
         empty    <= 1'b1;   // nothing stored out of reset
         rd_valid <= 1'b0;
      end else begin
         rd_bin   <= rd_bin_next;
         rd_gray  <= rd_gray_next;
         // empty once read pointer catches the synced write pointer
         empty    <= (rd_gray_next == wr_gray_sync[`FIFO_SYNC-1]);
         rd_valid <= rd_inc;  // lines up with registered ram data
      end
   end

   // note: empty can stay high a few cycles after a write lands,
   // the synchronizer delay makes it pessimistic, never optimistic

endmodule

// ==== oh_fifo_wptr.sv ====
/*
 * write domain pointer logic, all flops on wr_clk
 * rd_gray arrives from the read domain and is synchronized here
 * writes with full or bist_en high are dropped silently
 */
`timescale 1ns/1ps
`include "oh_fifo_consts.svh"

module oh_fifo_wptr (
   input  logic               wr_clk,       // write clock
   input  logic               wr_rst,       // sync reset, write domain
   input  logic               wr_en,        // write strobe
   input  logic               bist_en,      // bist holds the ram
   input  oh_fifo_pkg::ptr_t  rd_gray,      // read pointer, other domain
   output logic               full,         // registered full flag
   output logic               mem_wr_en,    // ram write strobe
   output oh_fifo_pkg::addr_t mem_wr_addr,  // ram write slot
   output oh_fifo_pkg::ptr_t  wr_gray       // registered gray pointer
);

   oh_fifo_pkg::ptr_t wr_bin;                     // binary write pointer
   oh_fifo_pkg::ptr_t wr_bin_next;
   oh_fifo_pkg::ptr_t wr_gray_next;
   oh_fifo_pkg::ptr_t rd_gray_sync [`FIFO_SYNC];  // synchronizer chain
   oh_fifo_pkg::ptr_t rd_gray_full;               // read ptr as full pattern
   logic              wr_inc;                     // accepted write

   assign wr_inc       = wr_en & ~full & ~bist_en;
   assign wr_bin_next  = wr_bin + oh_fifo_pkg::ptr_t'(wr_inc);
   assign wr_gray_next = (wr_bin_next >> 1) ^ wr_bin_next;

   // full when write is one lap ahead, i.e. top two gray bits flipped
   assign rd_gray_full = {~rd_gray_sync[`FIFO_SYNC-1][`FIFO_AW -: 2],
                          rd_gray_sync[`FIFO_SYNC-1][`FIFO_AW-2:0]};

   assign mem_wr_en   = wr_inc;                 // store on this edge
   assign mem_wr_addr = wr_bin[`FIFO_AW-1:0];   // drop wrap bit

   // ################################################
   // read pointer synchronizer
   // ################################################
   always_ff @(posedge wr_clk) begin
      if (wr_rst) begin
         for (int i = 0; i < `FIFO_SYNC; i++) begin
            rd_gray_sync[i] <= '0;
         end
      end else begin
         rd_gray_sync[0] <= rd_gray;  // first stage may go metastable
         for (int i = 1; i < `FIFO_SYNC; i++) begin
            rd_gray_sync[i] <= rd_gray_sync[i-1];
         end
      end
   end

   // ################################################
   // pointer and flag
   // ################################################
   always_ff @(posedge wr_clk) begin
      if (wr_rst) begin
         wr_bin  <= '0;
         wr_gray <= '0;
         full    <= 1'b0;
      end else begin
         wr_bin  <= wr_bin_next;
         wr_gray <= wr_gray_next;                  // only one bit moves
         full    <= (wr_gray_next == rd_gray_full);
      end
   end

endmodule

// ==== oh_memory_dp.sv ====
/*
 * dual port memory wrapper around the behavioral ram
 * bist port owns the write side while bist_en is high
 * functional writes always use a full word mask
 */
`timescale 1ns/1ps
`include "oh_fifo_consts.svh"

module oh_memory_dp #(
   parameter int DW    = `FIFO_DW,      // word width
   parameter int DEPTH = `FIFO_DEPTH,   // words, power of two
   localparam int AW   = $clog2(DEPTH)  // address width
) (
   // functional write port
   input  logic          wr_clk,     // write clock
   input  logic          wr_en,      // write strobe
   input  logic [AW-1:0] wr_addr,    // write slot
   input  logic [DW-1:0] wr_din,     // write data
   // read port
   input  logic          rd_clk,     // read clock
   input  logic          rd_en,      // read strobe
   input  logic [AW-1:0] rd_addr,    // read slot
   output logic [DW-1:0] rd_dout,    // read data
   // bist write port
   input  logic          bist_en,    // bist owns write port
   input  logic          bist_we,    // bist write strobe
   input  logic [DW-1:0] bist_wem,   // bist per bit enable
   input  logic [AW-1:0] bist_addr,  // bist slot
   input  logic [DW-1:0] bist_din    // bist data
);

   logic          ram_wr_en;    // muxed write strobe
   logic [DW-1:0] ram_wr_wem;   // muxed mask
   logic [AW-1:0] ram_wr_addr;  // muxed slot
   logic [DW-1:0] ram_wr_din;   // muxed data

   // ################################################
   // write port select
   // ################################################
   assign ram_wr_en   = bist_en ? bist_we   : wr_en;
   assign ram_wr_wem  = bist_en ? bist_wem  : {DW{1'b1}};  // full word
   assign ram_wr_addr = bist_en ? bist_addr : wr_addr;
   assign ram_wr_din  = bist_en ? bist_din  : wr_din;

   oh_memory_ram #(
      .DW    (DW),
      .DEPTH (DEPTH)
   ) oh_memory_ram (
      .wr_clk  (wr_clk),
      .wr_en   (ram_wr_en),
      .wr_wem  (ram_wr_wem),
      .wr_addr (ram_wr_addr),
      .wr_din  (ram_wr_din),
      .rd_clk  (rd_clk),      // read port passes through
      .rd_en   (rd_en),
      .rd_addr (rd_addr),
      .rd_dout (rd_dout)
   );

endmodule

// ==== oh_memory_ram.sv ====
/*
 * behavioral dual port ram, no reset on the array
 * write mask is per bit, read data is registered
 * rd_dout holds its value between read strobes
 */
`timescale 1ns/1ps
`include "oh_fifo_consts.svh"

module oh_memory_ram #(
   parameter int DW    = `FIFO_DW,      // word width
   parameter int DEPTH = `FIFO_DEPTH,   // words, power of two
   localparam int AW   = $clog2(DEPTH)  // address width
) (
   // write port
   input  logic          wr_clk,   // write clock
   input  logic          wr_en,    // write strobe
   input  logic [DW-1:0] wr_wem,   // per bit write enable
   input  logic [AW-1:0] wr_addr,  // write slot
   input  logic [DW-1:0] wr_din,   // write data
   // read port
   input  logic          rd_clk,   // read clock
   input  logic          rd_en,    // read strobe
   input  logic [AW-1:0] rd_addr,  // read slot
   output logic [DW-1:0] rd_dout   // registered read data
);

   logic [DW-1:0] mem [DEPTH];     // storage array

   // ################################################
   // write side
   // ################################################
   always_ff @(posedge wr_clk) begin
      if (wr_en) begin
         // masked bits take new data, the rest keep old value
         mem[wr_addr] <= (mem[wr_addr] & ~wr_wem) | (wr_din & wr_wem);
      end
   end

   // ################################################
   // read side
   // ################################################
   always_ff @(posedge rd_clk) begin
      if (rd_en) begin
         rd_dout <= mem[rd_addr];  // one cycle latency
      end
   end

endmodule

// ==== tb_clkgen.sv ====
/*
 * clocks and resets for both fifo domains
 * both clocks 8 ns, rd_clk rises 3 ns after wr_clk
 * each reset is held for 4 edges of its own clock
 */
`timescale 1ns/1ps

module tb_clkgen (
   output logic wr_clk,   // write domain clock
   output logic rd_clk,   // read domain clock
   output logic wr_rst,   // sync to wr_clk
   output logic rd_rst    // sync to rd_clk
);

   localparam int PERIOD     = 8;   // ns, both clocks
   localparam int RD_OFFSET  = 3;   // ns, read clock lag
   localparam int RST_CYCLES = 4;

   initial begin
      wr_clk = 1'b0;
      forever #(PERIOD/2) wr_clk = ~wr_clk;
   end

   initial begin
      rd_clk = 1'b0;
      #RD_OFFSET;
      forever #(PERIOD/2) rd_clk = ~rd_clk;
   end

   initial begin
      wr_rst = 1'b1;
      repeat (RST_CYCLES) @(posedge wr_clk);
      #1 wr_rst = 1'b0;   // release away from the edge
   end

   initial begin
      rd_rst = 1'b1;
      repeat (RST_CYCLES) @(posedge rd_clk);
      #1 rd_rst = 1'b0;
   end

endmodule

// ==== tb_fifo_assert.sv ====
/*
 * concurrent checks on the fifo flags and read strobes
 * bound into oh_fifo_async, fail_cnt counts failed assertions
 */
`timescale 1ns/1ps

module tb_fifo_assert (
   input logic wr_clk,
   input logic rd_clk,
   input logic wr_rst,
   input logic rd_rst,
   input logic full,
   input logic empty,
   input logic rd_en,
   input logic rd_valid
);

   int fail_cnt = 0;   // read by the testbench top

   // ################################################
   // flags
   // ################################################
   flags_exclusive: assert property (@(posedge wr_clk) disable iff (wr_rst || rd_rst)
                                     !(full && empty))
      else begin
         fail_cnt++;
         $error("full and empty high together");
      end

   full_after_reset: assert property (@(posedge wr_clk) wr_rst |=> !full)
      else begin
         fail_cnt++;
         $error("full not low after write reset");
      end

   empty_after_reset: assert property (@(posedge rd_clk) rd_rst |=> (empty && !rd_valid))
      else begin
         fail_cnt++;
         $error("empty or rd_valid wrong after read reset");
      end

   // ################################################
   // read strobe
   // ################################################
   valid_needs_read: assert property (@(posedge rd_clk) disable iff (rd_rst)
                                      rd_valid |-> $past(rd_en && !empty))
      else begin
         fail_cnt++;
         $error("rd_valid without an accepted read");
      end

   read_gives_valid: assert property (@(posedge rd_clk) disable iff (rd_rst)
                                      (rd_en && !empty) |=> rd_valid)
      else begin
         fail_cnt++;
         $error("accepted read not followed by rd_valid");
      end

endmodule

// ==== tb_fifo_check.sv ====
/*
 * fifo scoreboard, samples the DUT ports on the clock edges
 * words are queued with the slot they were written to
 * bist writes patch the queued word that sits in their slot
 */
`timescale 1ns/1ps
`include "oh_fifo_consts.svh"

module tb_fifo_check (
   input  logic               wr_clk,
   input  logic               wr_rst,
   input  logic               wr_en,
   input  oh_fifo_pkg::data_t wr_din,
   input  logic               full,
   input  logic               bist_en,
   input  logic               bist_we,
   input  oh_fifo_pkg::data_t bist_wem,
   input  oh_fifo_pkg::addr_t bist_addr,
   input  oh_fifo_pkg::data_t bist_din,
   input  logic               rd_clk,
   input  logic               rd_rst,
   input  logic               rd_valid,
   input  oh_fifo_pkg::data_t rd_dout,
   input  logic               end_check,     // rises once at end of run
   output int                 mismatch_cnt,  // wrong rd_dout values
   output int                 other_cnt,     // protocol errors
   output int                 model_cnt,     // words held by the model
   output int                 wr_accepted    // accepted writes so far
);

   oh_fifo_pkg::data_t data_q [$];   // expected words, oldest first
   oh_fifo_pkg::addr_t slot_q [$];   // slot of each queued word
   oh_fifo_pkg::data_t head;

   // expected word after a masked write, bit by bit
   function automatic oh_fifo_pkg::data_t masked_word(input oh_fifo_pkg::data_t old,
                                                       input oh_fifo_pkg::data_t mask,
                                                       input oh_fifo_pkg::data_t din);
      oh_fifo_pkg::data_t word;
      word = old;
      for (int b = 0; b < `FIFO_DW; b++) begin
         if (mask[b]) begin
            word[b] = din[b];   // set mask bit takes the bist bit
         end
      end
      return word;
   endfunction

   // slot of the n-th accepted write
   function automatic oh_fifo_pkg::addr_t slot_of(input int count);
      return oh_fifo_pkg::addr_t'(count % `FIFO_DEPTH);
   endfunction

   initial begin
      mismatch_cnt = 0;
      other_cnt    = 0;
      model_cnt    = 0;
      wr_accepted  = 0;
   end

   // ################################################
   // write side model
   // ################################################
   always @(posedge wr_clk) begin
      if (!wr_rst) begin
         if (bist_en && bist_we) begin
            foreach (slot_q[i]) begin
               if (slot_q[i] == bist_addr) begin
                  data_q[i] = masked_word(data_q[i], bist_wem, bist_din);
               end
            end
         end
         if (wr_en && !full && !bist_en) begin   // accepted write
            data_q.push_back(wr_din);
            slot_q.push_back(slot_of(wr_accepted));
            wr_accepted++;
         end
         model_cnt = data_q.size();
      end
   end

   // ################################################
   // read side compare
   // ################################################
   always @(posedge rd_clk) begin
      if (!rd_rst && rd_valid) begin
         if (data_q.size() == 0) begin
            other_cnt++;
            $display("error at %0t: rd_valid high while no word was expected", $time);
         end else begin
            head = data_q.pop_front();
            void'(slot_q.pop_front());
            if (rd_dout !== head) begin
               mismatch_cnt++;
               $display("[FAIL] t=%0t rd_dout exp %h got %h", $time, head, rd_dout);
            end
         end
         model_cnt = data_q.size();
      end
   end

   always @(posedge end_check) begin
      if (data_q.size() != 0) begin
         other_cnt++;
         $display("error: %0d written words were never read back", data_q.size());
      end
   end

endmodule

// ==== tb_oh_fifo_async.sv ====
/*
 * async fifo testbench, stimulus 1 ns after each clock edge
 * phases: reset, write and drain, fill, random traffic, bist
 * run is bounded by a write clock cycle counter
 */
`timescale 1ns/1ps
`include "oh_fifo_consts.svh"

module tb_oh_fifo_async;

   localparam int DRIVE_DLY   = 1;   // ns after the rising edge
   localparam int RANDOM_CYC  = 500;
   // reset, write and drain, fill, random, bist, then margin
   localparam int TIMEOUT_CYC = 4 + 40 + 50 + (RANDOM_CYC + 30) + 40 + 200;

   logic wr_clk, rd_clk, wr_rst, rd_rst;
   logic wr_en, rd_en, full, empty, rd_valid;
   logic bist_en, bist_we;
   oh_fifo_pkg::data_t wr_din, rd_dout, bist_wem, bist_din;
   oh_fifo_pkg::addr_t bist_addr;
   logic end_check;
   int   mismatch_cnt, other_cnt, model_cnt, wr_accepted;
   int   stim_errors = 0;
   int   cycles = 0;
   int   seed;
   int   base;

   tb_clkgen clkgen (.wr_clk(wr_clk), .rd_clk(rd_clk), .wr_rst(wr_rst), .rd_rst(rd_rst));

   oh_fifo_async DUT (
      .wr_clk(wr_clk), .rd_clk(rd_clk), .wr_rst(wr_rst), .rd_rst(rd_rst),
      .wr_en(wr_en), .wr_din(wr_din), .full(full),
      .rd_en(rd_en), .empty(empty), .rd_valid(rd_valid), .rd_dout(rd_dout),
      .bist_en(bist_en), .bist_we(bist_we), .bist_wem(bist_wem),
      .bist_addr(bist_addr), .bist_din(bist_din)
   );

   bind oh_fifo_async tb_fifo_assert fifo_assert (
      .wr_clk(wr_clk), .rd_clk(rd_clk), .wr_rst(wr_rst), .rd_rst(rd_rst),
      .full(full), .empty(empty), .rd_en(rd_en), .rd_valid(rd_valid)
   );

   tb_fifo_check check (
      .wr_clk(wr_clk), .wr_rst(wr_rst), .wr_en(wr_en), .wr_din(wr_din), .full(full),
      .bist_en(bist_en), .bist_we(bist_we), .bist_wem(bist_wem),
      .bist_addr(bist_addr), .bist_din(bist_din),
      .rd_clk(rd_clk), .rd_rst(rd_rst), .rd_valid(rd_valid), .rd_dout(rd_dout),
      .end_check(end_check), .mismatch_cnt(mismatch_cnt), .other_cnt(other_cnt),
      .model_cnt(model_cnt), .wr_accepted(wr_accepted)
   );

   // ################################################
   // helpers
   // ################################################
   task automatic expect_value(input string name, input int exp, input int got);
      if (exp != got) begin
         stim_errors++;
         $display("[FAIL] t=%0t %s exp %0d got %0d", $time, name, exp, got);
      end
   endtask

   task automatic write_words(input int n);
      repeat (n) begin
         @(posedge wr_clk);
         #DRIVE_DLY;
         wr_en  = 1'b1;
         wr_din = $random(seed);
      end
      @(posedge wr_clk);
      #DRIVE_DLY;
      wr_en = 1'b0;
   endtask

   task automatic fill_until_full;
      int extra;
      extra = 0;
      while (extra < 3) begin   // a few more strobes once full is up
         @(posedge wr_clk);
         #DRIVE_DLY;
         if (full) extra++;
         wr_en  = 1'b1;
         wr_din = $random(seed);
      end
      @(posedge wr_clk);
      #DRIVE_DLY;
      wr_en = 1'b0;
   endtask

   task automatic wait_not_empty;
      @(posedge rd_clk);
      while (empty) @(posedge rd_clk);
   endtask

   // read back to back until empty stays up for a while
   task automatic drain;
      int idle;
      idle = 0;
      while (idle < 6) begin
         @(posedge rd_clk);
         #DRIVE_DLY;
         rd_en = !empty;
         if (empty) idle++;
         else idle = 0;
      end
      rd_en = 1'b0;
   endtask

   task automatic bist_write(input oh_fifo_pkg::addr_t slot);
      @(posedge wr_clk);
      #DRIVE_DLY;
      bist_en   = 1'b1;
      bist_we   = 1'b1;
      bist_addr = slot;
      bist_wem  = $random(seed);
      bist_din  = $random(seed);
      wr_en     = 1'b1;           // must be dropped
      wr_din    = $random(seed);
      @(posedge wr_clk);
      #DRIVE_DLY;
      bist_we = 1'b0;
      bist_en = 1'b0;
      wr_en   = 1'b0;
   endtask

   task automatic finish_run;
      int total;
      end_check = 1'b1;
      #1;
      total = stim_errors + mismatch_cnt + other_cnt + DUT.fifo_assert.fail_cnt;
      $display("errors: stimulus %0d, data %0d, other %0d, assertion %0d",
               stim_errors, mismatch_cnt, other_cnt, DUT.fifo_assert.fail_cnt);
      if (total == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   endtask

   always @(posedge wr_clk) begin
      cycles++;
      if (cycles == TIMEOUT_CYC) begin
         stim_errors++;
         $display("timeout: run still going after %0d write clock cycles", cycles);
         finish_run();
      end
   end

   // ################################################
   // stimulus
   // ################################################
   initial begin
      seed      = 32'h0750_f680;
      wr_en     = 1'b0;
      wr_din    = '0;
      rd_en     = 1'b0;
      bist_en   = 1'b0;
      bist_we   = 1'b0;
      bist_wem  = '0;
      bist_addr = '0;
      bist_din  = '0;
      end_check = 1'b0;

      wait (!wr_rst && !rd_rst);   // reset state
      @(posedge rd_clk);
      #DRIVE_DLY;
      expect_value("empty", 1, int'(empty));
      expect_value("full", 0, int'(full));
      expect_value("rd_valid", 0, int'(rd_valid));

      write_words(10);              // write then drain
      wait_not_empty();
      drain();
      expect_value("model_cnt", 0, model_cnt);

      base = wr_accepted;           // fill to full
      fill_until_full();
      expect_value("accepted writes", `FIFO_DEPTH, wr_accepted - base);
      drain();
      expect_value("model_cnt", 0, model_cnt);

      fork                          // random traffic on both sides
         for (int i = 0; i < RANDOM_CYC; i++) begin
            @(posedge wr_clk);
            #DRIVE_DLY;
            wr_en  = (i < RANDOM_CYC/2) ? (($random(seed) & 3) != 0)
                                        : (($random(seed) & 3) == 0);
            wr_din = $random(seed);
         end
         for (int i = 0; i < RANDOM_CYC; i++) begin
            @(posedge rd_clk);
            #DRIVE_DLY;
            rd_en = ($random(seed) & 1) != 0;
         end
      join
      wr_en = 1'b0;
      drain();
      expect_value("model_cnt", 0, model_cnt);

      base = wr_accepted;           // bist masked write into second entry
      write_words(4);
      bist_write(oh_fifo_pkg::addr_t'((base + 1) % `FIFO_DEPTH));
      expect_value("model_cnt", 4, model_cnt);
      drain();
      expect_value("model_cnt", 0, model_cnt);

      finish_run();
   end

endmodule

// ==== vlog.f ====
+incdir+.
oh_fifo_pkg.sv
oh_memory_ram.sv
oh_memory_dp.sv
oh_fifo_wptr.sv
oh_fifo_rptr.sv
oh_fifo_async.sv
tb_clkgen.sv
tb_fifo_check.sv
tb_fifo_assert.sv
tb_oh_fifo_async.sv
